/* compile.f */
source/cpu_pkg.sv
source/step_timer.sv
source/mul_unit.sv
source/reg_file.sv
source/cpu_ctrl.sv
source/cpu_datapath.sv
source/cpu_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* Bender.yml */
package:
  name: cpu_multicycle

sources:
  - source/cpu_pkg.sv
  - source/step_timer.sv
  - source/mul_unit.sv
  - source/reg_file.sv
  - source/cpu_ctrl.sv
  - source/cpu_datapath.sv
  - source/cpu_top.sv
  - target: test
    files:
      - testbench/tb_checker.sv
      - testbench/tb_top.sv

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
	import cpu_pkg::*;

	localparam int PROG_LEN = 60;
	localparam int RUN_LIMIT = 30000;

	logic clk_i;
	logic rst_i;
	ibus_req_t ibus;
	logic ibus_ack;
	word_t ibus_dat;
	dbus_req_t dbus;
	logic dbus_ack;
	word_t dbus_dat;
	logic halted;
	logic finished;
	int checks;
	int mismatches;
	int errors;

	logic [15:0] lfsr_state;
	word_t imem [256];
	word_t dmem [256];
	word_t base_val [2];
	int ibus_wait;
	int dbus_wait;
	int cycles;

	// taps 16 14 13 11
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic int take_bits(int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++)
			v = (v << 1) | int'(next_bit());
		return v;
	endfunction

	function automatic word_t enc_reg(insn_type_t t, int op, int ra, int rb, int rc);
		insn_reg_t w;
		w = '0;
		w.itype = t;
		w.op = 4'(op);
		w.ra = 4'(ra);
		w.rb = 4'(rb);
		w.rc = 4'(rc);
		return w;
	endfunction

	function automatic word_t enc_imm(insn_type_t t, int op, int ra, int rb, int imm);
		insn_imm_t w;
		w = '0;
		w.itype = t;
		w.op = 4'(op);
		w.ra = 4'(ra);
		w.rb = 4'(rb);
		w.imm = 15'(imm); // two's complement for negative offsets
		return w;
	endfunction

	// r0..r5 hold data, r6 and r7 hold data-region base addresses
	task automatic build_program();
		int idx;
		int kind;
		int ra;
		int rb;
		int rc;
		int op;
		int off;
		branch_cond_t conds [6];
		word_t halt_word;
		conds = '{BR_BRA, BR_BEQ, BR_BNE, BR_BLT, BR_BLTU, BR_BGE};
		halt_word = enc_reg(T_INH, 4, 0, 0, 0);
		for (int i = 0; i < 256; i++)
		begin
			imem[i] = halt_word;
			dmem[i] = 32'h9e3779b9 * (i + 1);
		end
		for (int i = 0; i < 6; i++)
			imem[i] = enc_imm(T_LDI, 0, i, 0, take_bits(15));
		for (int i = 0; i < 2; i++)
		begin
			base_val[i] = word_t'(take_bits(8) * 4);
			imem[6 + i] = enc_imm(T_LDI, 0, 6 + i, 0, int'(base_val[i]));
		end
		idx = 8;
		while (idx < PROG_LEN - 1)
		begin
			kind = take_bits(3);
			ra = take_bits(3) % 6;
			rb = take_bits(3) % 6;
			case (kind)
				0: imem[idx] = enc_reg(T_CMP, 0, ra, rb, 0);
				1:
				begin
					op = take_bits(3) % 5;
					rc = take_bits(3) % 6;
					imem[idx] = enc_reg(T_ALU, op, ra, rb, rc);
				end
				2:
				begin
					rc = take_bits(3) % 6;
					imem[idx] = enc_reg(T_INT, 0, ra, rb, rc);
				end
				3, 4:
				begin
					rb = 6 + take_bits(1);
					off = take_bits(8) * 4 - int'(base_val[rb - 6]); // lands inside 1 KB
					if (kind == 3)
						imem[idx] = enc_imm(T_LOAD, 0, ra, rb, off);
					else
						imem[idx] = enc_imm(T_STORE, 0, ra, rb, off);
				end
				5:
				begin
					imem[idx] = enc_reg(T_CMP, 0, ra, rb, 0);
					if (idx < PROG_LEN - 2)
					begin
						idx++;
						op = take_bits(3) % 6;
						off = take_bits(2);
						if (off > PROG_LEN - 2 - idx)
							off = PROG_LEN - 2 - idx; // never past the halt
						imem[idx] = enc_imm(T_BRANCH, conds[op], 0, 0, off);
					end
				end
				6: imem[idx] = enc_imm(T_LDI, 0, ra, 0, take_bits(15));
				default: imem[idx] = enc_reg(T_INH, 0, 0, 0, 0);
			endcase
			idx++;
		end
		imem[PROG_LEN - 1] = halt_word;
	endtask

	initial
	begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	initial
	begin
		rst_i = 1'b1;
		ibus_ack = 1'b0;
		ibus_dat = '0;
		dbus_ack = 1'b0;
		dbus_dat = '0;
		ibus_wait = 0;
		dbus_wait = 0;
		lfsr_state = 16'd51784;
		build_program();
		repeat (3) @(negedge clk_i);
		rst_i = 1'b0;
		cycles = 0;
		while (!finished && cycles < RUN_LIMIT)
		begin
			@(negedge clk_i);
			cycles++;
		end
		if (!finished)
			$display("timeout: checker did not finish within %0d cycles", RUN_LIMIT);
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, errors);
		if (finished && mismatches == 0 && errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// instruction and data memory slaves
	always @(negedge clk_i)
	begin
		if (ibus_ack)
			ibus_ack = 1'b0;
		else if (ibus.cyc)
		begin
			if (ibus.stb)
				ibus_wait = take_bits(2);
			if (ibus_wait == 0)
			begin
				ibus_ack = 1'b1;
				ibus_dat = imem[ibus.adr[9:2]];
			end
			else
				ibus_wait--;
		end
		if (dbus_ack)
			dbus_ack = 1'b0;
		else if (dbus.cyc)
		begin
			if (dbus.stb)
				dbus_wait = take_bits(2);
			if (dbus_wait == 0)
			begin
				dbus_ack = 1'b1;
				if (dbus.we)
					dmem[dbus.adr[9:2]] = dbus.dat;
				else
					dbus_dat = dmem[dbus.adr[9:2]];
			end
			else
				dbus_wait--;
		end
	end

	cpu_top #(
		.MUL_BITS_PER_STEP(2),
		.COUNT_W          (5)
	) dut_i (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.ibus    (ibus),
		.ibus_ack(ibus_ack),
		.ibus_dat(ibus_dat),
		.dbus    (dbus),
		.dbus_ack(dbus_ack),
		.dbus_dat(dbus_dat),
		.halted  (halted)
	);

	tb_checker chk_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.ibus      (ibus),
		.ibus_ack  (ibus_ack),
		.ibus_dat  (ibus_dat),
		.dbus      (dbus),
		.dbus_ack  (dbus_ack),
		.halted    (halted),
		.finished  (finished),
		.checks    (checks),
		.mismatches(mismatches),
		.errors    (errors)
	);

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
	input  logic               clk_i,
	input  logic               rst_i,
	input  cpu_pkg::ibus_req_t ibus,
	input  logic               ibus_ack,
	input  cpu_pkg::word_t     ibus_dat,
	input  cpu_pkg::dbus_req_t dbus,
	input  logic               dbus_ack,
	input  logic               halted,
	output logic               finished,
	output int                 checks,
	output int                 mismatches,
	output int                 errors
);
	import cpu_pkg::*;

	localparam int RESET_LIMIT = 20;
	localparam int RUN_LIMIT = 20000;
	localparam int HALT_LIMIT = 10;
	localparam int QUIET_CYCLES = 100;

	word_t regs [16];
	word_t mem [256];
	word_t pc;
	ccr_t ccr;
	int executed;
	logic halt_done;
	logic pend_valid; // a load or store still owes its data transfer
	logic pend_we;
	word_t pend_adr;
	word_t pend_dat;
	logic ibus_busy;
	logic dbus_busy;
	logic ibus_stb_q;
	logic dbus_stb_q;

	task automatic compare_word(string name, word_t expected, word_t actual);
		checks++;
		if (expected !== actual)
		begin
			mismatches++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic report_error(string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	task automatic check_handshake(string bus, logic cyc, logic stb, logic ack,
		inout logic busy, inout logic stb_q);
		if (stb && !cyc)
			report_error({bus, " strobe without cyc"});
		if (stb && stb_q)
			report_error({bus, " strobe held longer than one cycle"});
		if (stb && busy)
			report_error({bus, " second strobe before ack"});
		if (!stb && busy && !cyc)
			report_error({bus, " cyc dropped before ack"});
		if (stb)
			busy = 1'b1;
		if (ack && cyc)
			busy = 1'b0;
		stb_q = stb;
	endtask

	task automatic check_reset_state();
		checks++;
		if ({ibus.cyc, ibus.stb, dbus.cyc, dbus.stb, dbus.we} !== 5'b0)
			report_error("bus control signals not idle during reset");
		if (halted !== 1'b0)
			report_error("halted not low during reset");
	endtask

	task automatic check_data_request();
		if (!pend_valid)
			report_error("data bus strobe without a load or store");
		else
		begin
			compare_word("data bus write enable", 32'(pend_we), 32'(dbus.we));
			compare_word("data bus select", 32'hf, 32'(dbus.sel));
			if (pend_we)
			begin
				compare_word("store address", pend_adr, dbus.adr);
				compare_word("store data", pend_dat, dbus.dat);
			end
			else
				compare_word("load address", pend_adr, dbus.adr);
			pend_valid = 1'b0;
		end
	endtask

	// ISA reference, one instruction per fetch
	task automatic execute(insn_u insn);
		word_t src_b;
		word_t src_c;
		word_t simm;
		reg_addr_t ra;
		logic taken;
		ra = insn.r.ra;
		src_b = regs[insn.r.rb];
		src_c = regs[insn.r.rc];
		simm = {{17{insn.i.imm[14]}}, insn.i.imm};
		taken = 1'b0;
		pc = pc + 32'd4;
		case (insn.r.itype)
			T_INH:
				if (insn.r.op == 4'h4)
					halt_done = 1'b1;
				else if (insn.r.op != 4'h0)
					report_error("program holds an unknown inherent instruction");
			T_CMP:
			begin
				ccr.eq = (regs[ra] == src_b);
				ccr.lt = ($signed(regs[ra]) < $signed(src_b));
				ccr.ltu = (regs[ra] < src_b);
			end
			T_ALU:
				case (alu_func_t'(insn.r.op[2:0]))
					ALU_SUB: regs[ra] = src_b - src_c;
					ALU_AND: regs[ra] = src_b & src_c;
					ALU_OR:  regs[ra] = src_b | src_c;
					ALU_XOR: regs[ra] = src_b ^ src_c;
					default: regs[ra] = src_b + src_c;
				endcase
			T_INT: regs[ra] = src_b * src_c; // low word only
			T_LDI: regs[ra] = {17'h0, insn.i.imm};
			T_LOAD:
			begin
				pend_valid = 1'b1;
				pend_we = 1'b0;
				pend_adr = src_b + simm;
				regs[ra] = mem[pend_adr[9:2]];
			end
			T_STORE:
			begin
				pend_valid = 1'b1;
				pend_we = 1'b1;
				pend_adr = src_b + simm;
				pend_dat = regs[ra];
				mem[pend_adr[9:2]] = pend_dat;
			end
			T_BRANCH:
			begin
				case (branch_cond_t'(insn.r.op))
					BR_BRA:  taken = 1'b1;
					BR_BEQ:  taken = ccr.eq;
					BR_BNE:  taken = !ccr.eq;
					BR_BLT:  taken = ccr.lt;
					BR_BGE:  taken = !ccr.lt;
					BR_BLTU: taken = ccr.ltu;
					default: report_error("program holds an unknown branch condition");
				endcase
				if (taken)
					pc = pc + (simm << 2);
			end
			default: report_error("program holds an unknown instruction class");
		endcase
	endtask

	task automatic watch_cycle();
		check_handshake("instruction bus", ibus.cyc, ibus.stb, ibus_ack, ibus_busy, ibus_stb_q);
		check_handshake("data bus", dbus.cyc, dbus.stb, dbus_ack, dbus_busy, dbus_stb_q);
		if (dbus.stb)
			check_data_request();
		if (ibus.cyc && ibus_ack)
		begin
			if (pend_valid)
			begin
				report_error("load or store finished without a data bus transfer");
				pend_valid = 1'b0;
			end
			if (executed == 0)
				compare_word("first fetch address", 32'h0, ibus.adr);
			compare_word("fetch address", pc, ibus.adr);
			execute(ibus_dat);
			executed++;
		end
	endtask

	initial
	begin
		int cnt;
		finished = 1'b0;
		checks = 0;
		mismatches = 0;
		errors = 0;
		pc = '0;
		ccr = '0;
		executed = 0;
		halt_done = 1'b0;
		pend_valid = 1'b0;
		pend_we = 1'b0;
		pend_adr = '0;
		pend_dat = '0;
		ibus_busy = 1'b0;
		dbus_busy = 1'b0;
		ibus_stb_q = 1'b0;
		dbus_stb_q = 1'b0;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'h9e3779b9 * (i + 1);

		cnt = 0;
		while (rst_i !== 1'b0 && cnt < RESET_LIMIT)
		begin
			@(posedge clk_i);
			cnt++;
			if (rst_i === 1'b0)
				watch_cycle();
			else if (cnt > 1)
				check_reset_state(); // registers settle on the first edge in reset
		end
		if (rst_i !== 1'b0)
			report_error("reset was never released");

		cnt = 0;
		while (!halt_done && cnt < RUN_LIMIT)
		begin
			@(posedge clk_i);
			watch_cycle();
			cnt++;
		end
		if (!halt_done)
			report_error("program did not reach its halt instruction in time");
		else
		begin
			cnt = 0;
			while (halted !== 1'b1 && cnt < HALT_LIMIT)
			begin
				@(posedge clk_i);
				watch_cycle();
				cnt++;
			end
			if (halted !== 1'b1)
				report_error("halted did not rise after the halt instruction");
			for (int k = 0; k < QUIET_CYCLES; k++)
			begin
				@(posedge clk_i);
				watch_cycle();
				if (ibus.stb || dbus.stb)
					report_error("bus strobe after halt");
				if (halted !== 1'b1)
					report_error("halted dropped after being set");
			end
		end
		finished = 1'b1;
	end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter int MUL_BITS_PER_STEP = 2,
	parameter int COUNT_W = 5
) (
	input  logic               clk_i,
	input  logic               rst_i,
	output cpu_pkg::ibus_req_t ibus,
	input  logic               ibus_ack,
	input  cpu_pkg::word_t     ibus_dat,
	output cpu_pkg::dbus_req_t dbus,
	input  logic               dbus_ack,
	input  cpu_pkg::word_t     dbus_dat,
	output logic               halted
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	insn_u insn;
	ccr_t  ccr;
	logic  ibus_cyc;
	logic  ibus_stb;
	logic  dbus_cyc;
	logic  dbus_stb;
	logic  dbus_we;
	word_t ibus_adr;
	word_t dbus_adr;
	word_t dbus_wdat;
	logic  timer_load;
	logic  timer_done;
	logic [COUNT_W-1:0] timer_value;

	assign ibus = '{cyc: ibus_cyc, stb: ibus_stb, adr: ibus_adr};
	assign dbus = '{cyc: dbus_cyc, stb: dbus_stb, we: dbus_we, sel: 4'hf,
		adr: dbus_adr, dat: dbus_wdat}; // word transfers only

	cpu_ctrl #(
		.MUL_BITS_PER_STEP(MUL_BITS_PER_STEP),
		.COUNT_W          (COUNT_W)
	) ctrl_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.insn       (insn),
		.ccr        (ccr),
		.ibus_ack   (ibus_ack),
		.dbus_ack   (dbus_ack),
		.timer_done (timer_done),
		.ctrl       (ctrl),
		.ibus_cyc   (ibus_cyc),
		.ibus_stb   (ibus_stb),
		.dbus_cyc   (dbus_cyc),
		.dbus_stb   (dbus_stb),
		.dbus_we    (dbus_we),
		.timer_load (timer_load),
		.timer_value(timer_value),
		.halted     (halted)
	);

	step_timer #(
		.COUNT_W(COUNT_W)
	) timer_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.load       (timer_load),
		.start_value(timer_value),
		.done       (timer_done)
	);

	cpu_datapath #(
		.MUL_BITS_PER_STEP(MUL_BITS_PER_STEP)
	) dp_i (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.ctrl     (ctrl),
		.ibus_dat (ibus_dat),
		.dbus_dat (dbus_dat),
		.insn     (insn),
		.ccr      (ccr),
		.ibus_adr (ibus_adr),
		.dbus_adr (dbus_adr),
		.dbus_wdat(dbus_wdat)
	);

endmodule

/* source/cpu_datapath.sv */
`timescale 1ns/1ps

module cpu_datapath #(
	parameter int MUL_BITS_PER_STEP = 2
) (
	input  logic           clk_i,
	input  logic           rst_i,
	input  cpu_pkg::ctrl_t ctrl,
	input  cpu_pkg::word_t ibus_dat,
	input  cpu_pkg::word_t dbus_dat,
	output cpu_pkg::insn_u insn,
	output cpu_pkg::ccr_t  ccr,
	output cpu_pkg::word_t ibus_adr,
	output cpu_pkg::word_t dbus_adr,
	output cpu_pkg::word_t dbus_wdat
);
	import cpu_pkg::*;

	insn_u ir;
	word_t pc;
	word_t a;
	word_t b;
	word_t mar;
	word_t mdr;
	word_t rd_data1;
	word_t rd_data2;
	word_t reg_in;
	word_t alu_in2;
	word_t alu_out;
	word_t product;
	word_t simm;
	word_t uimm;
	word_t bus_adr;

	assign insn = ir;
	assign simm = {{17{ir.i.imm[14]}}, ir.i.imm};
	assign uimm = {17'h0, ir.i.imm};

	// one address mux, the two buses never overlap
	assign bus_adr = ctrl.addr_from_mar ? mar : pc;
	assign ibus_adr = bus_adr;
	assign dbus_adr = bus_adr;
	assign dbus_wdat = mdr;

	assign alu_in2 = (ctrl.alu2_sel == ALU2_SIMM) ? simm : b;

	always_comb
	begin
		case (ctrl.alu_func)
			ALU_SUB: alu_out = a - alu_in2;
			ALU_AND: alu_out = a & alu_in2;
			ALU_OR:  alu_out = a | alu_in2;
			ALU_XOR: alu_out = a ^ alu_in2;
			default: alu_out = a + alu_in2;
		endcase
	end

	always_comb
	begin
		case (ctrl.reg_in_sel)
			RIN_UIMM: reg_in = uimm;
			RIN_DBUS: reg_in = dbus_dat;
			RIN_MUL:  reg_in = product;
			default:  reg_in = mdr;
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			pc <= '0;
			ccr <= '0;
		end
		else
		begin
			if (ctrl.pc_sel == PC_NEXT)
				pc <= pc + 32'd4;
			else if (ctrl.pc_sel == PC_REL)
				pc <= pc + {simm[29:0], 2'b00}; // pc already past the branch
			if (ctrl.ccr_write)
			begin
				ccr.eq <= (rd_data1 == rd_data2);
				ccr.lt <= ($signed(rd_data1) < $signed(rd_data2));
				ccr.ltu <= (rd_data1 < rd_data2);
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (ctrl.ir_write)
			ir <= ibus_dat;
		if (ctrl.a_write)
			a <= rd_data1;
		if (ctrl.b_write)
			b <= rd_data2;
		if (ctrl.mar_sel == MAR_ALU)
			mar <= alu_out;
		if (ctrl.mdr_sel == MDR_ALU)
			mdr <= alu_out;
		else if (ctrl.mdr_sel == MDR_A)
			mdr <= a;
	end

	reg_file regs_i (
		.clk_i   (clk_i),
		.rd_addr1(ctrl.rd_addr1),
		.rd_addr2(ctrl.rd_addr2),
		.wr_addr (ctrl.wr_addr),
		.wr_en   (ctrl.reg_write),
		.wr_data (reg_in),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2)
	);

	mul_unit #(
		.MUL_BITS_PER_STEP(MUL_BITS_PER_STEP)
	) mul_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.start       (ctrl.mul_start),
		.multiplicand(a),
		.multiplier  (b),
		.product     (product)
	);

endmodule

/* source/cpu_ctrl.sv */
`timescale 1ns/1ps

module cpu_ctrl #(
	parameter int MUL_BITS_PER_STEP = 2,
	parameter int COUNT_W = 5
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  cpu_pkg::insn_u    insn,
	input  cpu_pkg::ccr_t     ccr,
	input  logic              ibus_ack,
	input  logic              dbus_ack,
	input  logic              timer_done,
	output cpu_pkg::ctrl_t    ctrl,
	output logic              ibus_cyc,
	output logic              ibus_stb,
	output logic              dbus_cyc,
	output logic              dbus_stb,
	output logic              dbus_we,
	output logic              timer_load,
	output logic [COUNT_W-1:0] timer_value,
	output logic              halted
);
	import cpu_pkg::*;

	typedef enum logic [4:0] {
		S_FETCH, S_FWAIT, S_EVAL,
		S_ALU, S_ALU2, S_WB,
		S_MUL, S_MUL2, S_MULW, S_MUL3,
		S_LOAD, S_LOAD2, S_LOADW,
		S_STORE, S_STORE2, S_STOREW,
		S_HALT
	} state_t;

	state_t state;
	state_t state_next;
	logic ibus_cyc_next;
	logic ibus_stb_next;
	logic dbus_cyc_next;
	logic dbus_stb_next;
	logic dbus_we_next;
	logic fetch_go;
	logic taken;
	logic br_known;

	assign halted = (state == S_HALT);
	assign timer_value = COUNT_W'(32 / MUL_BITS_PER_STEP - 1); // zero on the last step

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			state <= S_FETCH;
			ibus_cyc <= 1'b0;
			ibus_stb <= 1'b0;
			dbus_cyc <= 1'b0;
			dbus_stb <= 1'b0;
			dbus_we <= 1'b0;
		end
		else
		begin
			state <= state_next;
			ibus_cyc <= ibus_cyc_next;
			ibus_stb <= ibus_stb_next;
			dbus_cyc <= dbus_cyc_next;
			dbus_stb <= dbus_stb_next;
			dbus_we <= dbus_we_next;
		end
	end

	always_comb
	begin
		br_known = 1'b1;
		case (branch_cond_t'(insn.r.op))
			BR_BRA:  taken = 1'b1;
			BR_BEQ:  taken = ccr.eq;
			BR_BNE:  taken = !ccr.eq;
			BR_BLT:  taken = ccr.lt;
			BR_BGE:  taken = !ccr.lt;
			BR_BLTU: taken = ccr.ltu;
			default:
			begin
				taken = 1'b0;
				br_known = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		state_next = state;
		ibus_cyc_next = ibus_cyc;
		ibus_stb_next = ibus_stb;
		dbus_cyc_next = dbus_cyc;
		dbus_stb_next = dbus_stb;
		dbus_we_next = dbus_we;
		timer_load = 1'b0;
		fetch_go = 1'b0;
		ctrl = '0;
		ctrl.rd_addr1 = insn.r.ra;
		ctrl.rd_addr2 = insn.r.rb;
		ctrl.wr_addr = insn.r.ra;

		case (state)
			S_FETCH: fetch_go = 1'b1;
			S_FWAIT:
			begin
				ibus_stb_next = 1'b0;
				if (ibus_ack)
				begin
					ibus_cyc_next = 1'b0;
					ctrl.ir_write = 1'b1;
					ctrl.pc_sel = PC_NEXT;
					state_next = S_EVAL;
				end
			end
			S_EVAL:
			begin
				ctrl.a_write = 1'b1; // A <= rA
				ctrl.b_write = 1'b1; // B <= rB
				state_next = S_HALT; // halt and anything unknown
				if (!insn.r.size)
				begin
					case (insn.r.itype)
						T_INH: fetch_go = (insn.r.op == 4'h0); // nop
						T_CMP:
						begin
							ctrl.ccr_write = (insn.r.op == 4'h0);
							fetch_go = (insn.r.op == 4'h0);
						end
						T_ALU:
							if (!insn.r.op[3] && insn.r.op[2:0] <= 3'd4)
								state_next = S_ALU;
						T_INT:
							if (insn.r.op == 4'h0) // mulu
								state_next = S_MUL;
						T_LDI:
						begin
							ctrl.reg_in_sel = RIN_UIMM;
							ctrl.reg_write = 1'b1;
							fetch_go = 1'b1;
						end
						T_LOAD:
							if (insn.r.op == 4'h0)
								state_next = S_LOAD;
						T_STORE:
							if (insn.r.op == 4'h0)
								state_next = S_STORE;
						T_BRANCH:
						begin
							ctrl.pc_sel = taken ? PC_REL : PC_PC;
							fetch_go = br_known;
						end
						default: state_next = S_HALT;
					endcase
				end
			end
			S_ALU:
			begin
				ctrl.rd_addr1 = insn.r.rb;
				ctrl.rd_addr2 = insn.r.rc;
				ctrl.a_write = 1'b1;
				ctrl.b_write = 1'b1;
				state_next = S_ALU2;
			end
			S_ALU2:
			begin
				ctrl.alu_func = alu_func_t'(insn.r.op[2:0]);
				ctrl.mdr_sel = MDR_ALU;
				state_next = S_WB;
			end
			S_WB:
			begin
				ctrl.reg_write = 1'b1; // rA <= MDR
				fetch_go = 1'b1;
			end
			S_MUL:
			begin
				ctrl.rd_addr1 = insn.r.rb;
				ctrl.rd_addr2 = insn.r.rc;
				ctrl.a_write = 1'b1;
				ctrl.b_write = 1'b1;
				state_next = S_MUL2;
			end
			S_MUL2:
			begin
				ctrl.mul_start = 1'b1;
				timer_load = 1'b1;
				state_next = S_MULW;
			end
			S_MULW:
				if (timer_done)
					state_next = S_MUL3;
			S_MUL3:
			begin
				ctrl.reg_in_sel = RIN_MUL;
				ctrl.reg_write = 1'b1;
				fetch_go = 1'b1;
			end
			S_LOAD:
			begin
				ctrl.rd_addr1 = insn.r.rb;
				ctrl.a_write = 1'b1; // A <= rB
				state_next = S_LOAD2;
			end
			S_LOAD2:
			begin
				ctrl.alu2_sel = ALU2_SIMM;
				ctrl.mar_sel = MAR_ALU;
				dbus_cyc_next = 1'b1;
				dbus_stb_next = 1'b1;
				state_next = S_LOADW;
			end
			S_LOADW:
			begin
				ctrl.addr_from_mar = 1'b1;
				dbus_stb_next = 1'b0;
				if (dbus_ack)
				begin
					dbus_cyc_next = 1'b0;
					ctrl.reg_in_sel = RIN_DBUS;
					ctrl.reg_write = 1'b1;
					fetch_go = 1'b1;
				end
			end
			S_STORE:
			begin
				ctrl.mdr_sel = MDR_A; // store data is rA
				ctrl.rd_addr1 = insn.r.rb;
				ctrl.a_write = 1'b1;
				state_next = S_STORE2;
			end
			S_STORE2:
			begin
				ctrl.alu2_sel = ALU2_SIMM;
				ctrl.mar_sel = MAR_ALU;
				dbus_cyc_next = 1'b1;
				dbus_stb_next = 1'b1;
				dbus_we_next = 1'b1;
				state_next = S_STOREW;
			end
			S_STOREW:
			begin
				ctrl.addr_from_mar = 1'b1;
				dbus_stb_next = 1'b0;
				if (dbus_ack)
				begin
					dbus_cyc_next = 1'b0;
					dbus_we_next = 1'b0;
					fetch_go = 1'b1;
				end
			end
			default: state_next = S_HALT;
		endcase

		if (fetch_go)
		begin
			ibus_cyc_next = 1'b1;
			ibus_stb_next = 1'b1;
			state_next = S_FWAIT;
		end
	end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic               clk_i,
	input  cpu_pkg::reg_addr_t rd_addr1,
	input  cpu_pkg::reg_addr_t rd_addr2,
	input  cpu_pkg::reg_addr_t wr_addr,
	input  logic               wr_en,
	input  cpu_pkg::word_t     wr_data,
	output cpu_pkg::word_t     rd_data1,
	output cpu_pkg::word_t     rd_data2
);
	import cpu_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk_i)
	begin
		if (wr_en)
			regs[wr_addr] <= wr_data;
	end

	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

/* source/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit #(
	parameter int MUL_BITS_PER_STEP = 2
) (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           start,
	input  cpu_pkg::word_t multiplicand,
	input  cpu_pkg::word_t multiplier,
	output cpu_pkg::word_t product
);
	import cpu_pkg::*;

	word_t mcand;
	word_t mplier;
	word_t partial;

	always_comb
	begin
		partial = '0;
		for (int i = 0; i < MUL_BITS_PER_STEP; i++)
			if (mplier[i])
				partial = partial + (mcand << i);
	end

	// once the multiplier is shifted out the sum stops changing
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			mcand <= '0;
			mplier <= '0;
			product <= '0;
		end
		else if (start)
		begin
			mcand <= multiplicand;
			mplier <= multiplier;
			product <= '0;
		end
		else
		begin
			product <= product + partial;
			mcand <= mcand << MUL_BITS_PER_STEP;
			mplier <= mplier >> MUL_BITS_PER_STEP;
		end
	end

endmodule

/* source/step_timer.sv */
`timescale 1ns/1ps

module step_timer #(
	parameter int COUNT_W = 5
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               load,
	input  logic [COUNT_W-1:0] start_value,
	output logic               done
);
	logic [COUNT_W-1:0] count;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			count <= '0;
		else if (load)
			count <= start_value;
		else if (count != '0)
			count <= count - 1'b1; // sticks at zero
	end

	assign done = (count == '0);

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_addr_t;

	typedef enum logic [3:0] {
		T_INH    = 4'h0,
		T_CMP    = 4'h3,
		T_INT    = 4'h6,
		T_ALU    = 4'h7,
		T_LDI    = 4'h8,
		T_LOAD   = 4'h9,
		T_STORE  = 4'ha,
		T_BRANCH = 4'hb
	} insn_type_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'h0,
		ALU_SUB = 3'h1,
		ALU_AND = 3'h2,
		ALU_OR  = 3'h3,
		ALU_XOR = 3'h4
	} alu_func_t;

	typedef enum logic [3:0] {
		BR_BRA  = 4'h0,
		BR_BEQ  = 4'h1,
		BR_BNE  = 4'h2,
		BR_BGE  = 4'h5,
		BR_BLT  = 4'h7,
		BR_BLTU = 4'h9
	} branch_cond_t;

	typedef struct packed {
		insn_type_t itype;
		logic [3:0] op;
		reg_addr_t  ra;
		reg_addr_t  rb;
		reg_addr_t  rc;
		logic [10:0] rsvd;
		logic       size; // two-word form, not supported
	} insn_reg_t;

	typedef struct packed {
		insn_type_t itype;
		logic [3:0] op;
		reg_addr_t  ra;
		reg_addr_t  rb;
		logic [14:0] imm;
		logic       size;
	} insn_imm_t;

	typedef union packed {
		insn_reg_t r;
		insn_imm_t i;
	} insn_u;

	typedef struct packed {
		logic ltu;
		logic lt;
		logic eq;
	} ccr_t;

	typedef enum logic {ALU2_B, ALU2_SIMM} alu2_sel_t;
	typedef enum logic [1:0] {RIN_MDR, RIN_UIMM, RIN_DBUS, RIN_MUL} reg_in_sel_t;
	typedef enum logic {MAR_MAR, MAR_ALU} mar_sel_t;
	typedef enum logic [1:0] {MDR_MDR, MDR_ALU, MDR_A} mdr_sel_t;
	typedef enum logic [1:0] {PC_PC, PC_NEXT, PC_REL} pc_sel_t;

	typedef struct packed {
		logic        ir_write;
		logic        a_write;
		logic        b_write;
		logic        reg_write;
		reg_addr_t   rd_addr1;
		reg_addr_t   rd_addr2;
		reg_addr_t   wr_addr;
		alu_func_t   alu_func;
		alu2_sel_t   alu2_sel;
		reg_in_sel_t reg_in_sel;
		mar_sel_t    mar_sel;
		mdr_sel_t    mdr_sel;
		pc_sel_t     pc_sel;
		logic        ccr_write;
		logic        addr_from_mar;
		logic        mul_start;
	} ctrl_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		word_t adr;
	} ibus_req_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [3:0] sel;
		word_t      adr;
		word_t      dat;
	} dbus_req_t;

endpackage
